// File: mipsPkg.sv
`default_nettype none

package mipsPkg;

  // ====================================================================
  // field and word types
  // ====================================================================

  // data and address word
  typedef logic [31:0] wordT;
  // register number
  typedef logic [4:0] regAddrT;
  // major opcode, instr[31:26]
  typedef logic [5:0] opcodeT;
  // r-type function code, instr[5:0]
  typedef logic [5:0] functT;
  // word index into either memory
  typedef logic [5:0] memIdxT;
  // j/jal target index, instr[25:0]
  typedef logic [25:0] jumpIdxT;

  // memory depth in words
  localparam int memWords = 64;
  // jal link register
  localparam regAddrT linkReg = 5'd31;

  // major opcodes
  localparam opcodeT opRType = 6'h00;
  localparam opcodeT opJ = 6'h02;
  localparam opcodeT opJal = 6'h03;
  localparam opcodeT opBeq = 6'h04;
  localparam opcodeT opLw = 6'h23;
  localparam opcodeT opSw = 6'h2b;

  // r-type function codes
  localparam functT fnJr = 6'h08;
  localparam functT fnAdd = 6'h20;
  localparam functT fnSub = 6'h22;
  localparam functT fnAnd = 6'h24;
  localparam functT fnOr = 6'h25;
  localparam functT fnSlt = 6'h2a;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt
  } aluOpT;

  // ====================================================================
  // bundles
  // ====================================================================

  // decoded control for one instruction
  typedef struct packed {
    logic    regWrite;
    logic    memToReg;
    logic    memWrite;
    logic    aluSrcImm;
    logic    linkWrite;
    logic    branch;
    logic    jump;
    logic    jumpReg;
    aluOpT   aluOp;
    regAddrT dest;
    // already sign extended
    wordT    imm;
    jumpIdxT jumpIdx;
  } ctrlT;

  // one retired instruction, as seen from outside
  typedef struct packed {
    wordT    pc;
    logic    regWrite;
    regAddrT regAddr;
    wordT    regData;
    logic    store;
    wordT    storeAddr;
    wordT    storeData;
  } retireT;

endpackage

`default_nettype wire

// File: mipsAlu.sv
`timescale 1ns/100ps
`default_nettype none

module mipsAlu (
  input  mipsPkg::aluOpT op,
  input  mipsPkg::wordT  a,
  input  mipsPkg::wordT  b,
  output mipsPkg::wordT  result,
  output logic           zero
);

  import mipsPkg::*;

  always_comb begin
    case (op)
      aluAdd: result = a + b;
      aluSub: result = a - b;
      aluAnd: result = a & b;
      aluOr: result = a | b;
      // signed compare
      aluSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: result = '0;
    endcase
  end

  // set for any op, beq only looks at it after sub
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: mipsDecode.sv
`timescale 1ns/100ps
`default_nettype none

module mipsDecode (
  input  mipsPkg::wordT    instr,
  output mipsPkg::ctrlT    ctrl,
  output mipsPkg::regAddrT rs,
  output mipsPkg::regAddrT rt
);

  import mipsPkg::*;

  opcodeT  opcode;
  functT   funct;
  regAddrT rd;

  // field split
  assign opcode = instr[31:26];
  assign funct = instr[5:0];
  assign rs = instr[25:21];
  assign rt = instr[20:16];
  assign rd = instr[15:11];

  // ====================================================================
  // main control and alu op selection
  // ====================================================================
  always_comb begin
    // defaults give a no-op that writes nothing and steps pc by 4
    ctrl = '0;
    ctrl.aluOp = aluAdd;
    ctrl.dest = rt;
    ctrl.imm = {{16{instr[15]}}, instr[15:0]};
    ctrl.jumpIdx = instr[25:0];
    case (opcode)
      opRType: begin
        ctrl.dest = rd;
        ctrl.regWrite = 1'b1;
        case (funct)
          fnAdd: ctrl.aluOp = aluAdd;
          fnSub: ctrl.aluOp = aluSub;
          fnAnd: ctrl.aluOp = aluAnd;
          fnOr: ctrl.aluOp = aluOr;
          fnSlt: ctrl.aluOp = aluSlt;
          fnJr: begin
            // jump through rs without write back
            ctrl.regWrite = 1'b0;
            ctrl.jumpReg = 1'b1;
          end
          default: begin
            // unknown function code
            ctrl.regWrite = 1'b0;
          end
        endcase
      end
      opLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      opSw: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      opBeq: begin
        // equality from the zero flag of rs minus rt
        ctrl.aluOp = aluSub;
        ctrl.branch = 1'b1;
      end
      opJ: begin
        ctrl.jump = 1'b1;
      end
      opJal: begin
        ctrl.jump = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.linkWrite = 1'b1;
        ctrl.dest = linkReg;
      end
      default: begin
        // unknown opcode keeps the no-op defaults
      end
    endcase
  end

endmodule

`default_nettype wire

// File: mipsRegFile.sv
`timescale 1ns/100ps
`default_nettype none

module mipsRegFile (
  input  logic             clk,
  input  logic             rst,
  input  mipsPkg::regAddrT rs,
  input  mipsPkg::regAddrT rt,
  output mipsPkg::wordT    rsData,
  output mipsPkg::wordT    rtData,
  input  logic             wbWrite,
  input  mipsPkg::regAddrT wbAddr,
  input  mipsPkg::wordT    wbData
);

  import mipsPkg::*;

  wordT regs [32];

  // write at the edge, register 0 never written
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wbWrite && (wbAddr != '0)) begin
      regs[wbAddr] <= wbData;
    end
  end

  // combinational reads
  // register 0 reads as zero
  assign rsData = (rs == '0) ? '0 : regs[rs];
  assign rtData = (rt == '0) ? '0 : regs[rt];

endmodule

`default_nettype wire

// File: mipsFetch.sv
`timescale 1ns/100ps
`default_nettype none

module mipsFetch (
  input  logic           clk,
  input  logic           rst,
  input  mipsPkg::ctrlT  ctrl,
  input  logic           zero,
  input  mipsPkg::wordT  rsData,
  output mipsPkg::wordT  pc,
  output mipsPkg::wordT  pcPlus4,
  output mipsPkg::wordT  instr
);

  import mipsPkg::*;

  // instruction memory, loaded once at time zero
  wordT   iMem [memWords];
  memIdxT iIdx;
  wordT   pcNext;
  wordT   branchTarget;
  wordT   jumpTarget;

  initial begin
    $readmemh("program.hex", iMem);
  end

  // low two bits of the byte address ignored
  assign iIdx = pc[7:2];
  assign instr = iMem[iIdx];

  assign pcPlus4 = pc + 32'd4;
  // offset counts words, relative to the next instruction
  assign branchTarget = pcPlus4 + {ctrl.imm[29:0], 2'b00};
  // keep the current 256 MB region
  assign jumpTarget = {pcPlus4[31:28], ctrl.jumpIdx, 2'b00};

  // ====================================================================
  // next pc, jr over j over taken beq over sequential
  // ====================================================================
  always_comb begin
    if (ctrl.jumpReg) begin
      pcNext = rsData;
    end else if (ctrl.jump) begin
      pcNext = jumpTarget;
    end else if (ctrl.branch && zero) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

// File: mipsMemStage.sv
`timescale 1ns/100ps
`default_nettype none

module mipsMemStage (
  input  logic             clk,
  input  logic             rst,
  input  mipsPkg::wordT    pc,
  input  mipsPkg::ctrlT    ctrl,
  input  mipsPkg::wordT    aluResult,
  input  mipsPkg::wordT    rtData,
  input  mipsPkg::wordT    pcPlus4,
  output logic             wbWrite,
  output mipsPkg::regAddrT wbAddr,
  output mipsPkg::wordT    wbData,
  output mipsPkg::retireT  retire
);

  import mipsPkg::*;

  wordT   dMem [memWords];
  memIdxT dIdx;
  wordT   loadWord;

  // ====================================================================
  // data memory
  // ====================================================================

  // word index from the byte address
  assign dIdx = aluResult[7:2];
  assign loadWord = dMem[dIdx];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < memWords; i++) begin
        dMem[i] <= '0;
      end
    end else if (ctrl.memWrite) begin
      dMem[dIdx] <= rtData;
    end
  end

  // ====================================================================
  // write back and retire record
  // ====================================================================
  assign wbWrite = ctrl.regWrite;
  assign wbAddr = ctrl.dest;

  always_comb begin
    if (ctrl.memToReg) begin
      wbData = loadWord;
    end else if (ctrl.linkWrite) begin
      // jal links to the next instruction, no delay slot
      wbData = pcPlus4;
    end else begin
      wbData = aluResult;
    end
  end

  always_comb begin
    retire.pc = pc;
    // flags held low while in reset
    retire.regWrite = ctrl.regWrite & rst;
    retire.regAddr = ctrl.dest;
    retire.regData = wbData;
    retire.store = ctrl.memWrite & rst;
    retire.storeAddr = aluResult;
    retire.storeData = rtData;
  end

endmodule

`default_nettype wire

// File: mipsCore.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCore (
  input  logic            clk,
  input  logic            rst,
  output mipsPkg::retireT retire
);

  import mipsPkg::*;

  // fetch side
  wordT    pc;
  wordT    pcPlus4;
  wordT    instr;
  // decode and operands
  ctrlT    ctrl;
  regAddrT rs;
  regAddrT rt;
  wordT    rsData;
  wordT    rtData;
  wordT    aluB;
  wordT    aluResult;
  logic    zero;
  // write back into the register file
  logic    wbWrite;
  regAddrT wbAddr;
  wordT    wbData;

  mipsFetch u_mipsFetch (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl),
    .zero    (zero),
    .rsData  (rsData),
    .pc      (pc),
    .pcPlus4 (pcPlus4),
    .instr   (instr)
  );

  mipsDecode u_mipsDecode (
    .instr (instr),
    .ctrl  (ctrl),
    .rs    (rs),
    .rt    (rt)
  );

  mipsRegFile u_mipsRegFile (
    .clk     (clk),
    .rst     (rst),
    .rs      (rs),
    .rt      (rt),
    .rsData  (rsData),
    .rtData  (rtData),
    .wbWrite (wbWrite),
    .wbAddr  (wbAddr),
    .wbData  (wbData)
  );

  // second operand, immediate for lw and sw
  assign aluB = ctrl.aluSrcImm ? ctrl.imm : rtData;

  mipsAlu u_mipsAlu (
    .op     (ctrl.aluOp),
    .a      (rsData),
    .b      (aluB),
    .result (aluResult),
    .zero   (zero)
  );

  mipsMemStage u_mipsMemStage (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .ctrl      (ctrl),
    .aluResult (aluResult),
    .rtData    (rtData),
    .pcPlus4   (pcPlus4),
    .wbWrite   (wbWrite),
    .wbAddr    (wbAddr),
    .wbData    (wbData),
    .retire    (retire)
  );

endmodule

`default_nettype wire

// File: tbClock.sv
`timescale 1ns/100ps
`default_nettype none

module tbClock (
  output logic clk,
  output logic rst
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset low for 3 cycles, released just after an edge
  initial begin
    rst = 1'b0;
    repeat (3) @(posedge clk);
    #1 rst = 1'b1;
  end

endmodule

`default_nettype wire

// File: tbMips.sv
`timescale 1ns/100ps
`default_nettype none

module tbMips;

  import mipsPkg::*;

  logic   clk;
  logic   rst;
  retireT retire;

  // instruction-set model state
  wordT   progMem [memWords];
  wordT   mRegs [32];
  wordT   mMem [memWords];
  wordT   mPc;

  int     errCount;
  int     checkCount;
  int     cycles;
  logic   timedOut;
  logic   done;
  retireT expRet;

  tbClock u_tbClock (
    .clk (clk),
    .rst (rst)
  );

  mipsCore u_mipsCore (
    .clk    (clk),
    .rst    (rst),
    .retire (retire)
  );

  // ====================================================================
  // reference model
  // ====================================================================

  // r0 always reads zero
  function automatic wordT readReg(input regAddrT n);
    if (n == 5'd0) begin
      return '0;
    end
    return mRegs[n];
  endfunction

  // one instruction, returns its retire record and commits its effects
  task automatic modelStep(output retireT exp, output logic halt);
    wordT ins;
    wordT a;
    wordT b;
    wordT seImm;
    wordT effAddr;
    wordT nextPc;
    ins = progMem[mPc[7:2]];
    a = readReg(ins[25:21]);
    b = readReg(ins[20:16]);
    seImm = {{16{ins[15]}}, ins[15:0]};
    effAddr = a + seImm;
    nextPc = mPc + 32'd4;
    exp = '0;
    exp.pc = mPc;
    case (ins[31:26])
      opRType: begin
        exp.regWrite = 1'b1;
        exp.regAddr = ins[15:11];
        case (ins[5:0])
          fnAdd: exp.regData = a + b;
          fnSub: exp.regData = a - b;
          fnAnd: exp.regData = a & b;
          fnOr: exp.regData = a | b;
          fnSlt: exp.regData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          fnJr: begin
            exp.regWrite = 1'b0;
            nextPc = a;
          end
          // unknown function, no-op
          default: exp.regWrite = 1'b0;
        endcase
      end
      opLw: begin
        exp.regWrite = 1'b1;
        exp.regAddr = ins[20:16];
        exp.regData = mMem[effAddr[7:2]];
      end
      opSw: begin
        exp.store = 1'b1;
        exp.storeAddr = effAddr;
        exp.storeData = b;
      end
      opBeq: begin
        // word offset from the next instruction
        if (a == b) begin
          nextPc = nextPc + {seImm[29:0], 2'b00};
        end
      end
      opJ: begin
        nextPc = {nextPc[31:28], ins[25:0], 2'b00};
      end
      opJal: begin
        exp.regWrite = 1'b1;
        exp.regAddr = linkReg;
        exp.regData = mPc + 32'd4;
        nextPc = {nextPc[31:28], ins[25:0], 2'b00};
      end
      default: begin
        // unknown opcode retires as a no-op
        exp.regWrite = 1'b0;
      end
    endcase
    if (exp.regWrite && (exp.regAddr != 5'd0)) begin
      mRegs[exp.regAddr] = exp.regData;
    end
    if (exp.store) begin
      mMem[exp.storeAddr[7:2]] = exp.storeData;
    end
    // program ends on a jump to itself
    halt = (nextPc == mPc);
    mPc = nextPc;
  endtask

  // ====================================================================
  // checks
  // ====================================================================
  task automatic checkWord(input string what, input wordT got, input wordT exp);
    checkCount++;
    assert (got === exp) else begin
      errCount++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // addr and data only matter when their flag is set
  task automatic checkRetire(input retireT exp);
    checkWord("retire pc", retire.pc, exp.pc);
    checkWord("regWrite flag", {31'b0, retire.regWrite}, {31'b0, exp.regWrite});
    if (exp.regWrite) begin
      checkWord("regAddr", {27'b0, retire.regAddr}, {27'b0, exp.regAddr});
      checkWord("regData", retire.regData, exp.regData);
    end
    checkWord("store flag", {31'b0, retire.store}, {31'b0, exp.store});
    if (exp.store) begin
      checkWord("storeAddr", retire.storeAddr, exp.storeAddr);
      checkWord("storeData", retire.storeData, exp.storeData);
    end
  endtask

  // ====================================================================
  // run
  // ====================================================================
  initial begin
    errCount = 0;
    checkCount = 0;
    cycles = 0;
    timedOut = 1'b0;
    done = 1'b0;
    expRet = '0;
    $readmemh("program.hex", progMem);
    for (int i = 0; i < 32; i++) begin
      mRegs[i] = '0;
    end
    for (int i = 0; i < memWords; i++) begin
      mMem[i] = '0;
    end
    mPc = '0;

    // sampled at falling edges, away from the updates
    @(negedge clk);
    while ((rst !== 1'b1) && !timedOut) begin
      checkWord("regWrite during reset", {31'b0, retire.regWrite}, '0);
      checkWord("store during reset", {31'b0, retire.store}, '0);
      @(negedge clk);
      cycles++;
      if (cycles >= 200) begin
        timedOut = 1'b1;
      end
    end

    // first cycle out of reset starts at address zero
    checkWord("pc after reset", retire.pc, '0);

    while (!done && !timedOut) begin
      modelStep(expRet, done);
      checkRetire(expRet);
      @(negedge clk);
      cycles++;
      if (!done && (cycles >= 200)) begin
        timedOut = 1'b1;
      end
    end

    if (timedOut) begin
      $display("timeout: program did not reach its final self-jump within 200 cycles");
    end
    $display("checks %0d, errors %0d, timeouts %0d", checkCount, errCount, timedOut ? 1 : 0);
    if ((errCount == 0) && !timedOut) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: program.hex
// one instruction word per line from address 0, then byte address and meaning
0C000002 // 00 jal 0x08, r31 = 4
08000003 // 04 j 0x0c
03E00008 // 08 jr r31
03FF0820 // 0c add r1, r31, r31
00011022 // 10 sub r2, r0, r1
0041182A // 14 slt r3, r2, r1
0022202A // 18 slt r4, r1, r2
003F2825 // 1c or r5, r1, r31
00453024 // 20 and r6, r2, r5
00210020 // 24 add r0, r1, r1
AC220004 // 28 sw r2, 4(r1)
8C07000C // 2c lw r7, 12(r0)
10E20001 // 30 beq r7, r2, +1 taken
00214820 // 34 add r9, r1, r1 skipped
10220005 // 38 beq r1, r2, +5 not taken
FC221234 // 3c unknown opcode
00221801 // 40 unknown function code
01435020 // 44 add r10, r10, r3
1143FFFE // 48 beq r10, r3, -2 back once
ACA60000 // 4c sw r6, 0(r5)
8CAB0000 // 50 lw r11, 0(r5)
00006020 // 54 add r12, r0, r0
08000016 // 58 j 0x58 self-jump

// File: flist.f
mipsPkg.sv
mipsAlu.sv
mipsDecode.sv
mipsRegFile.sv
mipsFetch.sv
mipsMemStage.sv
mipsCore.sv
tbClock.sv
tbMips.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - mipsPkg.sv
  - mipsAlu.sv
  - mipsDecode.sv
  - mipsRegFile.sv
  - mipsFetch.sv
  - mipsMemStage.sv
  - mipsCore.sv
  - target: test
    files:
      - tbClock.sv
      - tbMips.sv
